// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN          = 32;
    localparam int REG_COUNT_LOG = 5;

    typedef logic [XLEN-1:0]          data_t;
    typedef logic [REG_COUNT_LOG-1:0] reg_idx_t;
    typedef logic [3:0]               alu_op_t;    // funct7[5] and funct3
    typedef logic [2:0]               branch_op_t; // funct3 of the branch

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // R-format view, the other formats reuse its slices
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SRX = 3'b101;  // SRL and SRA
    localparam alu_op_t    ALU_ADD = 4'b0000;

    function automatic data_t imm_i(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic data_t imm_u(input logic [31:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

    function automatic data_t imm_b(input logic [31:0] instr);
        return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    endfunction

    function automatic data_t shamt(input logic [31:0] instr);
        return {27'b0, instr[24:20]};
    endfunction

endpackage

`default_nettype wire

// File: hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int ROB_TAG_BITS = 3;
    localparam int ROB_ENTRIES  = 7;  // Tag 0 is never handed out
    localparam int ALU_RS_DEPTH = 4;
    localparam int BCU_RS_DEPTH = 2;
    localparam int QUEUE_DEPTH  = 4;

    localparam int QUEUE_PTR_BITS  = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_BITS  = $clog2(QUEUE_DEPTH + 1);
    localparam int ROB_CREDIT_BITS = $clog2(ROB_ENTRIES + 1);
    localparam int ALU_CREDIT_BITS = $clog2(ALU_RS_DEPTH + 1);
    localparam int BCU_CREDIT_BITS = $clog2(BCU_RS_DEPTH + 1);

    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;  // 0 means value present

    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_LUI    = 2'd1,
        KIND_BRANCH = 2'd2
    } instr_kind_e;

    typedef struct packed {
        logic [31:0]     instr;
        isa_pkg::data_t  pc;
    } fetch_t;

    typedef struct packed {
        instr_kind_e         kind;
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::branch_op_t branch_op;
        isa_pkg::reg_idx_t   rd;
        isa_pkg::reg_idx_t   rs1;
        isa_pkg::reg_idx_t   rs2;
        logic                use_rs2;
        logic                use_pc_as_rs1;
        isa_pkg::data_t      imm;  // Branch target for branches
        isa_pkg::data_t      pc;
    } decoded_t;

    typedef struct packed {
        logic           valid;
        rob_tag_t       tag;
        isa_pkg::data_t value;
    } cdb_t;

    typedef struct packed {
        isa_pkg::alu_op_t op;
        isa_pkg::data_t   vj;
        isa_pkg::data_t   vk;
        rob_tag_t         qj;
        rob_tag_t         qk;
        rob_tag_t         dest;
    } alu_entry_t;

    typedef struct packed {
        isa_pkg::branch_op_t op;
        isa_pkg::data_t      vj;
        isa_pkg::data_t      vk;
        rob_tag_t            qj;
        rob_tag_t            qk;
        rob_tag_t            dest;
        isa_pkg::data_t      target;
        isa_pkg::data_t      fallthrough;
    } bcu_entry_t;

    typedef struct packed {
        isa_pkg::reg_idx_t dest;
        logic              value_ready;
        isa_pkg::data_t    value;
        logic              is_branch;
        isa_pkg::data_t    pc;
    } rob_entry_t;

    typedef struct packed {
        isa_pkg::reg_idx_t index;
        rob_tag_t          tag;
    } rename_t;

endpackage

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire                 clk_in,
    input  wire                 rst,
    input  wire                 fetch_valid,
    input  wire issue_pkg::fetch_t fetch,
    output logic                fetch_ready,
    input  wire                 almost_full,
    output logic                push,
    output issue_pkg::decoded_t item
);
    import isa_pkg::*;
    import issue_pkg::*;

    fetch_t        word_q;
    logic          word_valid;
    instr_fields_t f;
    logic          known;

    // Queue keeps one slot free for the word held here
    assign fetch_ready = !almost_full;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= fetch_valid && fetch_ready;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fetch_valid && fetch_ready) begin
            word_q <= fetch;
        end
    end

    assign f = instr_fields_t'(word_q.instr);

    always_comb begin
        item     = '0;
        item.pc  = word_q.pc;
        item.rd  = f.rd;
        item.rs1 = f.rs1;
        known    = 1'b1;
        case (f.opcode)
            OPC_OP: begin
                item.kind    = KIND_ALU;
                item.alu_op  = {f.funct7[5], f.funct3};
                item.rs2     = f.rs2;
                item.use_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                item.kind = KIND_ALU;
                if (f.funct3 == F3_SLL || f.funct3 == F3_SRX) begin
                    item.alu_op = {f.funct7[5], f.funct3};  // Bit 3 set for SRAI
                    item.imm    = shamt(word_q.instr);
                end else begin
                    item.alu_op = {1'b0, f.funct3};
                    item.imm    = imm_i(word_q.instr);
                end
            end
            OPC_AUIPC: begin
                item.kind          = KIND_ALU;
                item.alu_op        = ALU_ADD;
                item.rs1           = '0;
                item.use_pc_as_rs1 = 1'b1;
                item.imm           = imm_u(word_q.instr);
            end
            OPC_LUI: begin
                item.kind = KIND_LUI;
                item.rs1  = '0;
                item.imm  = imm_u(word_q.instr);
            end
            OPC_BRANCH: begin
                item.kind      = KIND_BRANCH;
                item.branch_op = f.funct3;
                item.rd        = '0;  // Field holds immediate bits
                item.rs2       = f.rs2;
                item.use_rs2   = 1'b1;
                item.imm       = imm_b(word_q.instr) + word_q.pc;  // Taken target
            end
            default: known = 1'b0;  // Dropped here
        endcase
    end

    assign push = word_valid && known;

endmodule

`default_nettype wire

// File: hdl/decoded_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module decoded_fifo (
    input  wire                    clk_in,
    input  wire                    rst,
    input  wire                    push,
    input  wire issue_pkg::decoded_t item,
    input  wire                    pop,
    output logic                   head_valid,
    output issue_pkg::decoded_t    head,
    output logic                   almost_full
);
    import issue_pkg::*;

    decoded_t                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [QUEUE_CNT_BITS-1:0] count;
    logic                      do_pop;

    function automatic logic [QUEUE_PTR_BITS-1:0] ptr_next(
        input logic [QUEUE_PTR_BITS-1:0] p
    );
        if (p == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + QUEUE_PTR_BITS'(1);
    endfunction

    assign head_valid  = (count != '0);
    assign head        = mem[rd_ptr];  // First-word fall-through
    assign almost_full = (count >= QUEUE_CNT_BITS'(QUEUE_DEPTH - 1));
    assign do_pop      = pop && head_valid;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin  // Room is guaranteed by almost_full
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + QUEUE_CNT_BITS'(push) - QUEUE_CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= item;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolver (
    input  wire isa_pkg::reg_idx_t   index,
    input  wire issue_pkg::rob_tag_t regfile_tag,
    input  wire isa_pkg::data_t      regfile_data,
    input  wire issue_pkg::cdb_t     cdb,
    input  wire                      last_rename_valid,
    input  wire issue_pkg::rename_t  last_rename,
    input  wire                      last_value_ready,
    input  wire isa_pkg::data_t      last_value,
    output isa_pkg::data_t           value,
    output issue_pkg::rob_tag_t      tag
);

    always_comb begin
        value = '0;
        tag   = '0;
        if (index == '0) begin
            // x0 reads as zero
        end else if (last_rename_valid && last_rename.index == index) begin
            // Register file has not seen the last rename yet
            if (last_value_ready) begin
                value = last_value;
            end else begin
                tag = last_rename.tag;
            end
        end else if (regfile_tag == '0) begin
            value = regfile_data;
        end else if (cdb.valid && cdb.tag == regfile_tag) begin
            value = cdb.value;  // Producer finishing this cycle
        end else begin
            tag = regfile_tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
    input  wire                      clk_in,
    input  wire                      rst,
    input  wire                      head_valid,
    input  wire issue_pkg::decoded_t head,
    output logic                     pop,
    output isa_pkg::reg_idx_t        rs1_index,
    output isa_pkg::reg_idx_t        rs2_index,
    input  wire issue_pkg::rob_tag_t rs1_tag,
    input  wire isa_pkg::data_t      rs1_data,
    input  wire issue_pkg::rob_tag_t rs2_tag,
    input  wire isa_pkg::data_t      rs2_data,
    input  wire issue_pkg::cdb_t     cdb,
    input  wire                      rob_credit,
    input  wire                      alu_credit,
    input  wire                      bcu_credit,
    output logic                     rename_valid,
    output issue_pkg::rename_t       rename,
    output logic                     rob_valid,
    output issue_pkg::rob_entry_t    rob,
    output logic                     alu_valid,
    output issue_pkg::alu_entry_t    alu,
    output logic                     bcu_valid,
    output issue_pkg::bcu_entry_t    bcu
);
    import isa_pkg::*;
    import issue_pkg::*;

    logic [ROB_CREDIT_BITS-1:0] rob_credits;
    logic [ALU_CREDIT_BITS-1:0] alu_credits;
    logic [BCU_CREDIT_BITS-1:0] bcu_credits;
    rob_tag_t                   next_tag;
    logic                       needs_alu;
    logic                       needs_bcu;
    logic                       can_issue;
    data_t                      rs1_value;
    data_t                      rs2_value;
    rob_tag_t                   rs1_q;
    rob_tag_t                   rs2_q;

    assign rs1_index = head.rs1;
    assign rs2_index = head.rs2;

    operand_resolver u_rs1 (
        .index(rs1_index), .regfile_tag(rs1_tag), .regfile_data(rs1_data), .cdb(cdb),
        .last_rename_valid(rename_valid), .last_rename(rename),
        .last_value_ready(rob.value_ready), .last_value(rob.value),
        .value(rs1_value), .tag(rs1_q)
    );

    operand_resolver u_rs2 (
        .index(rs2_index), .regfile_tag(rs2_tag), .regfile_data(rs2_data), .cdb(cdb),
        .last_rename_valid(rename_valid), .last_rename(rename),
        .last_value_ready(rob.value_ready), .last_value(rob.value),
        .value(rs2_value), .tag(rs2_q)
    );

    assign needs_alu = (head.kind == KIND_ALU);
    assign needs_bcu = (head.kind == KIND_BRANCH);
    assign can_issue = head_valid && rob_credits != '0
                       && (!needs_alu || alu_credits != '0)
                       && (!needs_bcu || bcu_credits != '0);
    assign pop = can_issue;  // Same edge as the issue registers

    always_ff @(posedge clk_in) begin
        if (rst) begin
            rob_credits  <= ROB_CREDIT_BITS'(ROB_ENTRIES);
            alu_credits  <= ALU_CREDIT_BITS'(ALU_RS_DEPTH);
            bcu_credits  <= BCU_CREDIT_BITS'(BCU_RS_DEPTH);
            next_tag     <= rob_tag_t'(1);
            rob_valid    <= 1'b0;
            alu_valid    <= 1'b0;
            bcu_valid    <= 1'b0;
            rename_valid <= 1'b0;
        end else begin
            rob_credits <= rob_credits + ROB_CREDIT_BITS'(rob_credit)
                           - ROB_CREDIT_BITS'(can_issue);
            alu_credits <= alu_credits + ALU_CREDIT_BITS'(alu_credit)
                           - ALU_CREDIT_BITS'(can_issue && needs_alu);
            bcu_credits <= bcu_credits + BCU_CREDIT_BITS'(bcu_credit)
                           - BCU_CREDIT_BITS'(can_issue && needs_bcu);
            if (can_issue) begin  // Tags run 1..7 and skip 0
                next_tag <= (next_tag == rob_tag_t'(ROB_ENTRIES)) ? rob_tag_t'(1)
                                                                 : next_tag + rob_tag_t'(1);
            end
            rob_valid    <= can_issue;
            alu_valid    <= can_issue && needs_alu;
            bcu_valid    <= can_issue && needs_bcu;
            rename_valid <= can_issue && !needs_bcu && head.rd != '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (can_issue) begin
            alu.op   <= head.alu_op;
            alu.vj   <= head.use_pc_as_rs1 ? head.pc : rs1_value;  // AUIPC
            alu.qj   <= head.use_pc_as_rs1 ? rob_tag_t'(0) : rs1_q;
            alu.vk   <= head.use_rs2 ? rs2_value : head.imm;
            alu.qk   <= head.use_rs2 ? rs2_q : rob_tag_t'(0);
            alu.dest <= next_tag;

            bcu.op          <= head.branch_op;
            bcu.vj          <= rs1_value;
            bcu.vk          <= rs2_value;
            bcu.qj          <= rs1_q;
            bcu.qk          <= rs2_q;
            bcu.dest        <= next_tag;
            bcu.target      <= head.imm;
            bcu.fallthrough <= head.pc + data_t'(4);

            rob.dest        <= needs_bcu ? reg_idx_t'(0) : head.rd;
            rob.value_ready <= (head.kind == KIND_LUI);
            rob.value       <= (head.kind == KIND_LUI) ? head.imm : data_t'(0);
            rob.is_branch   <= needs_bcu;
            rob.pc          <= head.pc;

            rename.index <= head.rd;
            rename.tag   <= next_tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  wire                      clk_in,
    input  wire                      rst,
    input  wire                      fetch_valid,
    input  wire issue_pkg::fetch_t   fetch,
    output logic                     fetch_ready,
    output isa_pkg::reg_idx_t        rs1_index,
    output isa_pkg::reg_idx_t        rs2_index,
    input  wire issue_pkg::rob_tag_t rs1_tag,
    input  wire isa_pkg::data_t      rs1_data,
    input  wire issue_pkg::rob_tag_t rs2_tag,
    input  wire isa_pkg::data_t      rs2_data,
    input  wire issue_pkg::cdb_t     cdb,
    output logic                     rename_valid,
    output issue_pkg::rename_t       rename,
    output logic                     rob_valid,
    output issue_pkg::rob_entry_t    rob,
    output logic                     alu_valid,
    output issue_pkg::alu_entry_t    alu,
    output logic                     bcu_valid,
    output issue_pkg::bcu_entry_t    bcu,
    input  wire                      rob_credit,
    input  wire                      alu_credit,
    input  wire                      bcu_credit
);
    import issue_pkg::*;

    logic     dec_push;
    decoded_t dec_item;
    logic     q_head_valid;
    decoded_t q_head;
    logic     q_pop;
    logic     q_almost_full;

    instr_decoder u_decoder (
        .clk_in(clk_in), .rst(rst), .fetch_valid(fetch_valid), .fetch(fetch),
        .fetch_ready(fetch_ready), .almost_full(q_almost_full),
        .push(dec_push), .item(dec_item)
    );

    decoded_fifo u_queue (
        .clk_in(clk_in), .rst(rst), .push(dec_push), .item(dec_item), .pop(q_pop),
        .head_valid(q_head_valid), .head(q_head), .almost_full(q_almost_full)
    );

    dispatch_unit u_dispatch (
        .clk_in(clk_in), .rst(rst), .head_valid(q_head_valid), .head(q_head), .pop(q_pop),
        .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rs1_tag(rs1_tag), .rs1_data(rs1_data), .rs2_tag(rs2_tag), .rs2_data(rs2_data),
        .cdb(cdb), .rob_credit(rob_credit), .alu_credit(alu_credit), .bcu_credit(bcu_credit),
        .rename_valid(rename_valid), .rename(rename), .rob_valid(rob_valid), .rob(rob),
        .alu_valid(alu_valid), .alu(alu), .bcu_valid(bcu_valid), .bcu(bcu)
    );

endmodule

`default_nettype wire

// File: verification/issue_tests.svh
task automatic test_r_type();
    logic [6:0] f7;
    logic [2:0] f3;
    reg_idx_t rs1;
    reg_idx_t rs2;
    start_test("r_type");
    for (int i = 0; i < 9; i++) begin  // Nine issues cover the wrap from 7 to 1
        f7 = (i % 3 == 1) ? 7'b0100000 : 7'b0000000;
        f3 = (i % 2 == 0) ? 3'b000 : 3'b101;
        rs1 = reg_idx_t'(1 + i % 4);
        rs2 = reg_idx_t'(5 + i % 3);
        expect_alu({f7[5], f3}, reg_data[rs1], reg_data[rs2], '0, '0,
                   reg_idx_t'(20 + i), data_t'(32'h100 + 4 * i));
        send(enc_r(f7, rs2, rs1, f3, reg_idx_t'(20 + i)), data_t'(32'h100 + 4 * i));
    end
    end_test();
endtask

task automatic test_i_type();
    start_test("i_type");
    expect_alu(4'b0000, reg_data[1], 32'hFFFF_FFFB, '0, '0, 5'd21, 32'h200);
    send(enc_i(12'hFFB, 5'd1, 3'b000, 5'd21), 32'h200);  // ADDI -5
    expect_alu(4'b1101, reg_data[2], 32'd7, '0, '0, 5'd22, 32'h204);
    send(enc_i(12'h407, 5'd2, 3'b101, 5'd22), 32'h204);  // SRAI 7
    expect_alu(4'b0111, reg_data[3], 32'h0000_07F0, '0, '0, 5'd23, 32'h208);
    send(enc_i(12'h7F0, 5'd3, 3'b111, 5'd23), 32'h208);
    expect_alu(4'b0000, 32'h1000, 32'h1234_5000, '0, '0, 5'd24, 32'h1000);
    send(enc_u(20'h12345, 5'd24, 7'b0010111), 32'h1000);  // AUIPC
    end_test();
endtask

task automatic test_lui_unknown();
    start_test("lui_unknown");
    expect_lui(5'd24, 32'hABCD_E000, 32'h300);
    send(enc_u(20'hABCDE, 5'd24, 7'b0110111), 32'h300);
    send(32'hFFFF_FF8B, 32'h304);  // Custom opcode with no output
    expect_alu(4'b0000, reg_data[1], reg_data[2], '0, '0, 5'd25, 32'h308);
    send(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd25), 32'h308);
    end_test();
endtask

task automatic test_dependency();
    rob_tag_t prev;
    data_t cdb_value;
    start_test("dependency");
    prev = exp_tag;
    expect_alu(4'b0000, reg_data[1], reg_data[2], '0, '0, 5'd5, 32'h400);
    send(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd5), 32'h400);
    expect_alu(4'b0000, '0, reg_data[3], prev, '0, 5'd6, 32'h404);
    send(enc_r(7'b0, 5'd3, 5'd5, 3'b000, 5'd6), 32'h404);
    wait_idle();
    expect_lui(5'd7, 32'h5555_5000, 32'h408);
    send(enc_u(20'h55555, 5'd7, 7'b0110111), 32'h408);
    expect_alu(4'b0000, 32'h5555_5000, reg_data[3], '0, '0, 5'd8, 32'h40C);
    send(enc_r(7'b0, 5'd3, 5'd7, 3'b000, 5'd8), 32'h40C);
    wait_idle();
    cdb_value = data_t'($random(seed));
    reg_tag[9] <= 3'd6;  // Producer finishes on the CDB
    cdb <= '{valid: 1'b1, tag: 3'd6, value: cdb_value};
    expect_alu(4'b0000, cdb_value, reg_data[3], '0, '0, 5'd10, 32'h410);
    send(enc_r(7'b0, 5'd3, 5'd9, 3'b000, 5'd10), 32'h410);
    wait_idle();
    cdb <= '0;
    end_test();
endtask

task automatic test_branch();
    start_test("branch");
    expect_branch(3'b000, reg_data[1], reg_data[2], 32'h510, 32'h500);
    send(enc_b(16, 5'd2, 5'd1, 3'b000), 32'h500);  // BEQ forward
    expect_branch(3'b001, reg_data[3], reg_data[4], 32'h5F8, 32'h600);
    send(enc_b(-8, 5'd4, 5'd3, 3'b001), 32'h600);  // BNE backward
    end_test();
endtask

task automatic test_backpressure();
    int base;
    int n;
    start_test("backpressure");
    base = alu_seen;
    hold_alu = 1'b1;
    for (int i = 0; i < 7; i++) begin
        expect_alu(4'b0000, reg_data[1 + i % 4], reg_data[2], '0, '0,
                   reg_idx_t'(20 + i), data_t'(32'h700 + 4 * i));
        send(enc_r(7'b0, 5'd2, reg_idx_t'(1 + i % 4), 3'b000, reg_idx_t'(20 + i)),
             data_t'(32'h700 + 4 * i));
    end
    fetch_valid <= 1'b0;
    n = 0;
    while (fetch_ready && n < 40) begin
        @(posedge clk_in);
        n++;
    end
    if (fetch_ready) begin
        $display("Timeout in test %s: fetch_ready never fell", cur_test);
        errors++;
    end
    repeat (4) @(posedge clk_in);
    check("alu issues held", 160'(ALU_RS_DEPTH), 160'(alu_seen - base));
    hold_alu = 1'b0;
    wait_idle();
    check("alu issues total", 160'(7), 160'(alu_seen - base));
    end_test();
endtask

// File: verification/issue_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb;
    import isa_pkg::*;
    import issue_pkg::*;

    logic clk_in;
    logic rst;
    logic fetch_valid;
    fetch_t fetch;
    logic fetch_ready;
    reg_idx_t rs1_index;
    reg_idx_t rs2_index;
    cdb_t cdb;
    logic rename_valid;
    rename_t rename;
    logic rob_valid;
    rob_entry_t rob;
    logic alu_valid;
    alu_entry_t alu;
    logic bcu_valid;
    bcu_entry_t bcu;
    logic rob_credit;
    logic alu_credit;
    logic bcu_credit;

    rob_tag_t reg_tag [32];  // Register file model
    data_t reg_data [32];
    alu_entry_t exp_alu [$];
    bcu_entry_t exp_bcu [$];
    rob_entry_t exp_rob [$];
    rename_t exp_ren [$];
    rob_tag_t exp_tag;
    int seed;
    int errors;
    int tests;
    int test_errors_start;
    int alu_seen;
    int rob_pend;
    int alu_pend;
    int bcu_pend;
    bit hold_alu;  // Withholds ALU credits
    string cur_test;

    issue_stage UUT (
        .clk_in(clk_in), .rst(rst), .fetch_valid(fetch_valid), .fetch(fetch),
        .fetch_ready(fetch_ready), .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rs1_tag(reg_tag[rs1_index]), .rs1_data(reg_data[rs1_index]),
        .rs2_tag(reg_tag[rs2_index]), .rs2_data(reg_data[rs2_index]), .cdb(cdb),
        .rename_valid(rename_valid), .rename(rename), .rob_valid(rob_valid), .rob(rob),
        .alu_valid(alu_valid), .alu(alu), .bcu_valid(bcu_valid), .bcu(bcu),
        .rob_credit(rob_credit), .alu_credit(alu_credit), .bcu_credit(bcu_credit)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check(input string what, input logic [159:0] expected,
                         input logic [159:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // Compares every issue pulse with the oldest expected entry
    always @(posedge clk_in) begin
        if (!rst) begin
            if (alu_valid) begin
                alu_seen++;
                if (exp_alu.size() == 0) begin
                    $display("Unexpected ALU issue in test %s", cur_test);
                    errors++;
                end else begin
                    check("alu entry", 160'(exp_alu.pop_front()), 160'(alu));
                end
            end
            if (bcu_valid) begin
                if (exp_bcu.size() == 0) begin
                    $display("Unexpected branch issue in test %s", cur_test);
                    errors++;
                end else begin
                    check("bcu entry", 160'(exp_bcu.pop_front()), 160'(bcu));
                end
            end
            if (rob_valid) begin
                if (exp_rob.size() == 0) begin
                    $display("Unexpected ROB entry in test %s", cur_test);
                    errors++;
                end else begin
                    check("rob entry", 160'(exp_rob.pop_front()), 160'(rob));
                end
            end
            if (rename_valid) begin
                if (exp_ren.size() == 0) begin
                    $display("Unexpected rename in test %s", cur_test);
                    errors++;
                end else begin
                    check("rename", 160'(exp_ren.pop_front()), 160'(rename));
                end
                reg_tag[rename.index] <= rename.tag;  // Seen one edge late
            end
        end
    end

    // Each pulse comes back as one credit per cycle
    always @(posedge clk_in) begin
        if (rst) begin
            rob_pend = 0;
            alu_pend = 0;
            bcu_pend = 0;
            rob_credit <= 1'b0;
            alu_credit <= 1'b0;
            bcu_credit <= 1'b0;
        end else begin
            if (rob_valid) rob_pend++;
            if (alu_valid) alu_pend++;
            if (bcu_valid) bcu_pend++;
            rob_credit <= (rob_pend != 0);
            if (rob_pend != 0) rob_pend--;
            alu_credit <= (alu_pend != 0 && !hold_alu);
            if (alu_pend != 0 && !hold_alu) alu_pend--;
            bcu_credit <= (bcu_pend != 0);
            if (bcu_pend != 0) bcu_pend--;
        end
    end

    function automatic rob_tag_t take_tag();
        rob_tag_t t;
        t = exp_tag;
        exp_tag = (exp_tag == rob_tag_t'(ROB_ENTRIES)) ? 3'd1 : exp_tag + 3'd1;
        return t;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input int off, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3);
        logic [12:0] b;
        b = off[12:0];
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], 7'b1100011};
    endfunction

    task automatic expect_alu(input alu_op_t op, input data_t vj, input data_t vk,
                              input rob_tag_t qj, input rob_tag_t qk,
                              input reg_idx_t rd, input data_t pc);
        rob_tag_t t;
        t = take_tag();
        exp_alu.push_back('{op: op, vj: vj, vk: vk, qj: qj, qk: qk, dest: t});
        exp_rob.push_back('{dest: rd, value_ready: 1'b0, value: '0, is_branch: 1'b0, pc: pc});
        if (rd != '0) exp_ren.push_back('{index: rd, tag: t});
    endtask

    task automatic expect_lui(input reg_idx_t rd, input data_t value, input data_t pc);
        rob_tag_t t;
        t = take_tag();
        exp_rob.push_back('{dest: rd, value_ready: 1'b1, value: value, is_branch: 1'b0,
                            pc: pc});
        if (rd != '0) exp_ren.push_back('{index: rd, tag: t});
    endtask

    task automatic expect_branch(input branch_op_t op, input data_t vj, input data_t vk,
                                 input data_t target, input data_t pc);
        rob_tag_t t;
        t = take_tag();
        exp_bcu.push_back('{op: op, vj: vj, vk: vk, qj: '0, qk: '0, dest: t,
                            target: target, fallthrough: pc + 32'd4});
        exp_rob.push_back('{dest: '0, value_ready: 1'b0, value: '0, is_branch: 1'b1, pc: pc});
    endtask

    task automatic send(input logic [31:0] instr, input data_t pc);
        int n;
        n = 0;
        fetch_valid <= 1'b1;
        fetch <= '{instr: instr, pc: pc};
        do begin
            @(posedge clk_in);
            n++;
        end while (!fetch_ready && n < 60);
        if (!fetch_ready) begin
            $display("Timeout in test %s: the fetch word was never accepted", cur_test);
            errors++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        fetch_valid <= 1'b0;
        while (exp_alu.size() + exp_bcu.size() + exp_rob.size() + exp_ren.size() != 0
               && n < 100) begin
            @(posedge clk_in);
            n++;
        end
        if (exp_alu.size() + exp_bcu.size() + exp_rob.size() + exp_ren.size() != 0) begin
            $display("Timeout in test %s: expected issues never appeared", cur_test);
            errors++;
            exp_alu.delete();
            exp_bcu.delete();
            exp_rob.delete();
            exp_ren.delete();
        end
        repeat (6) @(posedge clk_in);  // Let credits and renames settle
    endtask

    task automatic clear_regs();
        for (int i = 0; i < 32; i++) begin
            reg_tag[i] = '0;
            reg_data[i] = (i == 0) ? '0 : data_t'($random(seed));
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors_start = errors;
        clear_regs();
    endtask

    task automatic end_test();
        wait_idle();
        tests++;
        $display("%-14s %s", cur_test, (errors == test_errors_start) ? "passed" : "failed");
    endtask

    `include "issue_tests.svh"

    initial begin
        seed = 32'h3738;
        errors = 0;
        tests = 0;
        alu_seen = 0;
        hold_alu = 1'b0;
        exp_tag = 3'd1;
        cur_test = "reset";
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch = '0;
        cdb = '0;
        rob_credit = 1'b0;
        alu_credit = 1'b0;
        bcu_credit = 1'b0;
        clear_regs();
        repeat (16) @(posedge clk_in);
        rst <= 1'b0;
        @(posedge clk_in);
        test_r_type();
        test_i_type();
        test_lui_unknown();
        test_dependency();
        test_branch();
        test_backpressure();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: issue_stage.f
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/instr_decoder.sv
hdl/decoded_fifo.sv
hdl/operand_resolver.sv
hdl/dispatch_unit.sv
hdl/issue_stage.sv
+incdir+verification
verification/issue_stage_tb.sv

// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing -j 0
TOP       ?= issue_stage_tb
FILE_LIST ?= issue_stage.f
BUILD_DIR ?= obj_dir
PASS_TEXT := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
